// File: rtl/issue_pkg.sv
package issue_pkg;

    localparam int BUNDLE_W  = 69;
    localparam int REG_COUNT = 32;
    localparam int XLEN      = 64;
    localparam int IMM_IN_W  = 32;

    typedef logic [BUNDLE_W-1:0]  bundle_t;
    typedef logic [4:0]           reg_addr_t;
    typedef logic [REG_COUNT-1:0] reg_mask_t;
    typedef logic [XLEN-1:0]      imm_t;

    // xarith controls, lsb first
    // opsel[1:0], sub, unsigned, cmp_mode, branch_equal, branch_invert, word
    typedef logic [7:0] xarith_ctrl_t;

    // xlogic controls, lsb first
    // opsel[2:0], invert, sll[1:0], word
    typedef logic [6:0] xlogic_ctrl_t;

    // the decoder only ever emits these two codes for this core
    typedef enum logic [3:0] {
        pipe_xarith = 4'd0,
        pipe_xlogic = 4'd1
    } pipe_e;

    typedef enum logic {
        pair_idle,
        pair_first_sent
    } pair_state_e;

    // bundle layout, bit 0 carries nothing the issue stage needs
    localparam int RS1_LSB        = 1;
    localparam int RS2_LSB        = 6;
    localparam int RD_LSB         = 11;
    localparam int IMM_LSB        = 16;
    localparam int PIPE_LSB       = 48;
    localparam int RS2_UNUSED_BIT = 52;
    localparam int OP2_IMM_BIT    = 53;
    localparam int XARITH_LSB     = 54;
    localparam int XLOGIC_LSB     = 62;

endpackage

// File: rtl/bundle_unpack.sv
`timescale 1ns/10ps

module bundle_unpack import issue_pkg::*; (
    input  bundle_t      i_bundle,
    output reg_addr_t    o_rs1,
    output reg_addr_t    o_rs2,
    output reg_addr_t    o_rd,
    output imm_t         o_imm,
    output pipe_e        o_pipe,
    output logic         o_op2_imm,
    output xarith_ctrl_t o_xarith_ctrl,
    output xlogic_ctrl_t o_xlogic_ctrl,
    output reg_mask_t    o_hazard_mask
);

    logic [IMM_IN_W-1:0] imm_raw;
    logic                rs2_unused;
    reg_mask_t           rs2_mask;

    assign o_rs1 = i_bundle[RS1_LSB +: $bits(reg_addr_t)];
    assign o_rs2 = i_bundle[RS2_LSB +: $bits(reg_addr_t)];
    assign o_rd  = i_bundle[RD_LSB +: $bits(reg_addr_t)];

    assign imm_raw = i_bundle[IMM_LSB +: IMM_IN_W];
    assign o_imm   = {{(XLEN - IMM_IN_W){imm_raw[IMM_IN_W-1]}}, imm_raw};

    assign o_pipe        = pipe_e'(i_bundle[PIPE_LSB +: $bits(pipe_e)]);
    assign o_op2_imm     = i_bundle[OP2_IMM_BIT];
    assign o_xarith_ctrl = i_bundle[XARITH_LSB +: $bits(xarith_ctrl_t)];
    assign o_xlogic_ctrl = i_bundle[XLOGIC_LSB +: $bits(xlogic_ctrl_t)];

    // rs2 only counts as a source when the instruction actually reads it
    assign rs2_unused = i_bundle[RS2_UNUSED_BIT];
    assign rs2_mask   = (reg_mask_t'(1) << o_rs2) & {REG_COUNT{!rs2_unused}};

    // destination is included so that WAW against in-flight writes also stalls
    assign o_hazard_mask = (reg_mask_t'(1) << o_rs1) | rs2_mask | (reg_mask_t'(1) << o_rd);

endmodule

// File: rtl/reservation_table.sv
`timescale 1ns/10ps

module reservation_table import issue_pkg::*; (
    input  logic      i_clk,
    input  logic      i_rst_n,
    input  reg_mask_t i_mask0,
    input  reg_mask_t i_mask1,
    input  reg_addr_t i_rd0,
    input  reg_addr_t i_rd1,
    input  logic      i_transmit0,
    input  logic      i_transmit1,
    input  reg_mask_t i_retire0,
    input  reg_mask_t i_retire1,
    output logic      o_clear0,
    output logic      o_clear1
);

    // one bit per register with a write still in flight
    reg_mask_t inflight_q;
    reg_mask_t reserve;
    reg_mask_t retire;

    assign o_clear0 = (inflight_q & i_mask0) == '0;
    assign o_clear1 = (inflight_q & i_mask1) == '0;

    // x0 is hardwired to zero, so a write to it never needs tracking
    assign reserve = ((reg_mask_t'(i_transmit0) << i_rd0) |
                      (reg_mask_t'(i_transmit1) << i_rd1)) & ~reg_mask_t'(1);
    assign retire  = i_retire0 | i_retire1;

    // a new reservation wins over a retire of the same register in one cycle
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            inflight_q <= '0;
        end else begin
            inflight_q <= (inflight_q & ~retire) | reserve;
        end
    end

endmodule

// File: rtl/dispatch_ctrl.sv
`timescale 1ns/10ps

module dispatch_ctrl import issue_pkg::*; (
    input  logic      i_clk,
    input  logic      i_rst_n,
    input  logic      i_input_valid,
    input  pipe_e     i_pipe0,
    input  pipe_e     i_pipe1,
    input  reg_addr_t i_rd0,
    input  reg_addr_t i_rd1,
    input  logic      i_clear0,
    input  logic      i_clear1,
    input  logic      i_xarith_ready,
    input  logic      i_xlogic_ready,
    output logic      o_transmit0,
    output logic      o_transmit1,
    output logic      o_xarith_transmit,
    output logic      o_xarith_sel1,
    output logic      o_xlogic_transmit,
    output logic      o_xlogic_sel1,
    output logic      o_input_ready
);

    pair_state_e state_q;
    logic        first_sent;
    logic        pair_waw;
    logic        b0_ready;
    logic        b1_ready;
    logic        b0_unit_ready;
    logic        b1_unit_ready;
    logic        b1_route_ok;

    assign first_sent = state_q == pair_first_sent;

    // bundle 0 is only a candidate until it has gone out once
    assign b0_ready = i_input_valid && i_clear0 && !first_sent;

    // equal destinations in one pair could retire out of order, x0 included
    assign pair_waw = !first_sent && (i_rd0 == i_rd1);
    assign b1_ready = i_input_valid && i_clear1 && !pair_waw && (b0_ready || first_sent);

    // a pipe code outside the two units never finds a ready unit
    assign b0_unit_ready = (i_pipe0 == pipe_xarith && i_xarith_ready) ||
                           (i_pipe0 == pipe_xlogic && i_xlogic_ready);
    assign b1_unit_ready = (i_pipe1 == pipe_xarith && i_xarith_ready) ||
                           (i_pipe1 == pipe_xlogic && i_xlogic_ready);

    assign o_transmit0 = b0_ready && b0_unit_ready;

    // from idle, bundle 1 only leaves together with bundle 0 and on the other unit,
    // which keeps order and never drops a stalled bundle 0
    assign b1_route_ok = first_sent || (o_transmit0 && i_pipe1 != i_pipe0);
    assign o_transmit1 = b1_ready && b1_route_ok && b1_unit_ready;

    assign o_xarith_sel1     = o_transmit1 && i_pipe1 == pipe_xarith;
    assign o_xarith_transmit = (o_transmit0 && i_pipe0 == pipe_xarith) || o_xarith_sel1;
    assign o_xlogic_sel1     = o_transmit1 && i_pipe1 == pipe_xlogic;
    assign o_xlogic_transmit = (o_transmit0 && i_pipe0 == pipe_xlogic) || o_xlogic_sel1;

    // the pair is consumed once its second instruction is out
    assign o_input_ready = o_transmit1;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q <= pair_idle;
        end else if (o_transmit1) begin
            state_q <= pair_idle;
        end else if (o_transmit0) begin
            state_q <= pair_first_sent;
        end
    end

endmodule

// File: rtl/xarith_port.sv
`timescale 1ns/10ps

module xarith_port import issue_pkg::*; (
    input  logic         i_clk,
    input  logic         i_rst_n,
    input  logic         i_transmit,
    input  logic         i_sel1,
    input  xarith_ctrl_t i_ctrl0,
    input  xarith_ctrl_t i_ctrl1,
    input  imm_t         i_imm0,
    input  imm_t         i_imm1,
    input  reg_addr_t    i_rd0,
    input  reg_addr_t    i_rd1,
    input  logic         i_op2_imm0,
    input  logic         i_op2_imm1,
    output logic         o_banksel,
    output logic         o_op2_sel,
    output imm_t         o_imm,
    output logic [1:0]   o_opsel,
    output logic         o_sub,
    output logic         o_unsigned,
    output logic         o_cmp_mode,
    output logic         o_branch_equal,
    output logic         o_branch_invert,
    output logic         o_word,
    output reg_addr_t    o_rd,
    output logic         o_valid
);

    xarith_ctrl_t ctrl_q;

    // controls hold their last value between instructions
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_valid   <= 1'b0;
            o_banksel <= 1'b0;
            o_op2_sel <= 1'b0;
            o_imm     <= '0;
            o_rd      <= '0;
            ctrl_q    <= '0;
        end else begin
            o_valid <= i_transmit;
            if (i_transmit) begin
                o_banksel <= i_sel1;
                o_op2_sel <= i_sel1 ? i_op2_imm1 : i_op2_imm0;
                o_imm     <= i_sel1 ? i_imm1 : i_imm0;
                o_rd      <= i_sel1 ? i_rd1 : i_rd0;
                ctrl_q    <= i_sel1 ? i_ctrl1 : i_ctrl0;
            end
        end
    end

    assign o_opsel         = ctrl_q[1:0];
    assign o_sub           = ctrl_q[2];
    assign o_unsigned      = ctrl_q[3];
    assign o_cmp_mode      = ctrl_q[4];
    assign o_branch_equal  = ctrl_q[5];
    assign o_branch_invert = ctrl_q[6];
    assign o_word          = ctrl_q[7];

endmodule

// File: rtl/xlogic_port.sv
`timescale 1ns/10ps

module xlogic_port import issue_pkg::*; (
    input  logic         i_clk,
    input  logic         i_rst_n,
    input  logic         i_transmit,
    input  logic         i_sel1,
    input  xlogic_ctrl_t i_ctrl0,
    input  xlogic_ctrl_t i_ctrl1,
    input  imm_t         i_imm0,
    input  imm_t         i_imm1,
    input  reg_addr_t    i_rd0,
    input  reg_addr_t    i_rd1,
    input  logic         i_op2_imm0,
    input  logic         i_op2_imm1,
    output logic         o_banksel,
    output logic         o_op2_sel,
    output imm_t         o_imm,
    output logic [2:0]   o_opsel,
    output logic         o_invert,
    output logic [1:0]   o_sll,
    output logic         o_word,
    output reg_addr_t    o_rd,
    output logic         o_valid
);

    xlogic_ctrl_t ctrl_q;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_valid   <= 1'b0;
            o_banksel <= 1'b0;
            o_op2_sel <= 1'b0;
            o_imm     <= '0;
            o_rd      <= '0;
            ctrl_q    <= '0;
        end else begin
            o_valid <= i_transmit;
            if (i_transmit) begin
                // banksel picks rs3/rs4 on the register file for bundle 1
                o_banksel <= i_sel1;
                o_op2_sel <= i_sel1 ? i_op2_imm1 : i_op2_imm0;
                o_imm     <= i_sel1 ? i_imm1 : i_imm0;
                o_rd      <= i_sel1 ? i_rd1 : i_rd0;
                ctrl_q    <= i_sel1 ? i_ctrl1 : i_ctrl0;
            end
        end
    end

    assign o_opsel  = ctrl_q[2:0];
    assign o_invert = ctrl_q[3];
    assign o_sll    = ctrl_q[5:4];
    assign o_word   = ctrl_q[6];

endmodule

// File: rtl/warp_issue.sv
`timescale 1ns/10ps

module warp_issue import issue_pkg::*; (
    input  logic       i_clk,
    input  logic       i_rst_n,
    output logic       o_input_ready,
    input  logic       i_input_valid,
    input  bundle_t    i_bundle0,
    input  bundle_t    i_bundle1,
    // register file read addresses, rs1/rs2 of bundle 0 then of bundle 1
    output reg_addr_t  o_rs1_addr,
    output reg_addr_t  o_rs2_addr,
    output reg_addr_t  o_rs3_addr,
    output reg_addr_t  o_rs4_addr,
    output logic       o_xarith_banksel,
    output logic       o_xarith_op2_sel,
    output imm_t       o_xarith_imm,
    output logic [1:0] o_xarith_opsel,
    output logic       o_xarith_sub,
    output logic       o_xarith_unsigned,
    output logic       o_xarith_cmp_mode,
    output logic       o_xarith_branch_equal,
    output logic       o_xarith_branch_invert,
    output logic       o_xarith_word,
    output reg_addr_t  o_xarith_rd,
    output logic       o_xarith_valid,
    input  logic       i_xarith_ready,
    output logic       o_xlogic_banksel,
    output logic       o_xlogic_op2_sel,
    output imm_t       o_xlogic_imm,
    output logic [2:0] o_xlogic_opsel,
    output logic       o_xlogic_invert,
    output logic [1:0] o_xlogic_sll,
    output logic       o_xlogic_word,
    output reg_addr_t  o_xlogic_rd,
    output logic       o_xlogic_valid,
    input  logic       i_xlogic_ready,
    // back ends release destination registers as they retire
    input  reg_mask_t  i_inst0_retire,
    input  reg_mask_t  i_inst1_retire
);

    reg_addr_t    rd0;
    reg_addr_t    rd1;
    imm_t         imm0;
    imm_t         imm1;
    pipe_e        pipe0;
    pipe_e        pipe1;
    logic         op2_imm0;
    logic         op2_imm1;
    xarith_ctrl_t xarith_ctrl0;
    xarith_ctrl_t xarith_ctrl1;
    xlogic_ctrl_t xlogic_ctrl0;
    xlogic_ctrl_t xlogic_ctrl1;
    reg_mask_t    mask0;
    reg_mask_t    mask1;
    logic         clear0;
    logic         clear1;
    logic         transmit0;
    logic         transmit1;
    logic         xarith_transmit;
    logic         xarith_sel1;
    logic         xlogic_transmit;
    logic         xlogic_sel1;

    bundle_unpack u_unpack0 (
        .i_bundle      (i_bundle0),
        .o_rs1         (o_rs1_addr),
        .o_rs2         (o_rs2_addr),
        .o_rd          (rd0),
        .o_imm         (imm0),
        .o_pipe        (pipe0),
        .o_op2_imm     (op2_imm0),
        .o_xarith_ctrl (xarith_ctrl0),
        .o_xlogic_ctrl (xlogic_ctrl0),
        .o_hazard_mask (mask0)
    );

    bundle_unpack u_unpack1 (
        .i_bundle      (i_bundle1),
        .o_rs1         (o_rs3_addr),
        .o_rs2         (o_rs4_addr),
        .o_rd          (rd1),
        .o_imm         (imm1),
        .o_pipe        (pipe1),
        .o_op2_imm     (op2_imm1),
        .o_xarith_ctrl (xarith_ctrl1),
        .o_xlogic_ctrl (xlogic_ctrl1),
        .o_hazard_mask (mask1)
    );

    reservation_table u_reservation (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_mask0     (mask0),
        .i_mask1     (mask1),
        .i_rd0       (rd0),
        .i_rd1       (rd1),
        .i_transmit0 (transmit0),
        .i_transmit1 (transmit1),
        .i_retire0   (i_inst0_retire),
        .i_retire1   (i_inst1_retire),
        .o_clear0    (clear0),
        .o_clear1    (clear1)
    );

    dispatch_ctrl u_dispatch (
        .i_clk             (i_clk),
        .i_rst_n           (i_rst_n),
        .i_input_valid     (i_input_valid),
        .i_pipe0           (pipe0),
        .i_pipe1           (pipe1),
        .i_rd0             (rd0),
        .i_rd1             (rd1),
        .i_clear0          (clear0),
        .i_clear1          (clear1),
        .i_xarith_ready    (i_xarith_ready),
        .i_xlogic_ready    (i_xlogic_ready),
        .o_transmit0       (transmit0),
        .o_transmit1       (transmit1),
        .o_xarith_transmit (xarith_transmit),
        .o_xarith_sel1     (xarith_sel1),
        .o_xlogic_transmit (xlogic_transmit),
        .o_xlogic_sel1     (xlogic_sel1),
        .o_input_ready     (o_input_ready)
    );

    xarith_port u_xarith_port (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_transmit      (xarith_transmit),
        .i_sel1          (xarith_sel1),
        .i_ctrl0         (xarith_ctrl0),
        .i_ctrl1         (xarith_ctrl1),
        .i_imm0          (imm0),
        .i_imm1          (imm1),
        .i_rd0           (rd0),
        .i_rd1           (rd1),
        .i_op2_imm0      (op2_imm0),
        .i_op2_imm1      (op2_imm1),
        .o_banksel       (o_xarith_banksel),
        .o_op2_sel       (o_xarith_op2_sel),
        .o_imm           (o_xarith_imm),
        .o_opsel         (o_xarith_opsel),
        .o_sub           (o_xarith_sub),
        .o_unsigned      (o_xarith_unsigned),
        .o_cmp_mode      (o_xarith_cmp_mode),
        .o_branch_equal  (o_xarith_branch_equal),
        .o_branch_invert (o_xarith_branch_invert),
        .o_word          (o_xarith_word),
        .o_rd            (o_xarith_rd),
        .o_valid         (o_xarith_valid)
    );

    xlogic_port u_xlogic_port (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_transmit (xlogic_transmit),
        .i_sel1     (xlogic_sel1),
        .i_ctrl0    (xlogic_ctrl0),
        .i_ctrl1    (xlogic_ctrl1),
        .i_imm0     (imm0),
        .i_imm1     (imm1),
        .i_rd0      (rd0),
        .i_rd1      (rd1),
        .i_op2_imm0 (op2_imm0),
        .i_op2_imm1 (op2_imm1),
        .o_banksel  (o_xlogic_banksel),
        .o_op2_sel  (o_xlogic_op2_sel),
        .o_imm      (o_xlogic_imm),
        .o_opsel    (o_xlogic_opsel),
        .o_invert   (o_xlogic_invert),
        .o_sll      (o_xlogic_sll),
        .o_word     (o_xlogic_word),
        .o_rd       (o_xlogic_rd),
        .o_valid    (o_xlogic_valid)
    );

endmodule

// File: testbench/tb_warp_issue.sv
`timescale 1ns/10ps

module tb_warp_issue;

    localparam int NSTEPS      = 12;
    localparam int WORDS       = 21;
    localparam int STEP_CYCLES = 40;
    localparam int WATCHDOG_NS = NSTEPS * STEP_CYCLES * 20 + 200;

    logic        i_clk;
    logic        i_rst_n;
    logic        i_input_valid;
    logic [68:0] i_bundle0;
    logic [68:0] i_bundle1;
    logic        i_xarith_ready;
    logic        i_xlogic_ready;
    logic [31:0] i_inst0_retire;
    logic [31:0] i_inst1_retire;
    logic        o_input_ready;
    logic [4:0]  o_rs1_addr, o_rs2_addr, o_rs3_addr, o_rs4_addr;
    logic        o_xarith_banksel, o_xarith_op2_sel, o_xarith_valid;
    logic [63:0] o_xarith_imm;
    logic [1:0]  o_xarith_opsel;
    logic        o_xarith_sub, o_xarith_unsigned, o_xarith_cmp_mode;
    logic        o_xarith_branch_equal, o_xarith_branch_invert, o_xarith_word;
    logic [4:0]  o_xarith_rd;
    logic        o_xlogic_banksel, o_xlogic_op2_sel, o_xlogic_valid;
    logic [63:0] o_xlogic_imm;
    logic [2:0]  o_xlogic_opsel;
    logic        o_xlogic_invert, o_xlogic_word;
    logic [1:0]  o_xlogic_sll;
    logic [4:0]  o_xlogic_rd;

    logic [31:0] stim_mem [0:NSTEPS*WORDS-1];

    // fields of the pair under test, index 0 is bundle 0
    logic [4:0]  b_rs1 [0:1];
    logic [4:0]  b_rs2 [0:1];
    logic [4:0]  b_rd [0:1];
    logic [3:0]  b_pipe [0:1];
    logic [1:0]  b_sh [0:1];
    logic [7:0]  b_actrl [0:1];
    logic [6:0]  b_lctrl [0:1];
    logic [31:0] b_imm [0:1];
    logic        delivered [0:1];
    int          dcyc [0:1];

    // scoreboard model and the inputs seen in the previous cycle
    logic [31:0] sb_model;
    logic [31:0] ret_prev;
    logic        ir_prev;
    logic        ardy_prev;
    logic        lrdy_prev;
    logic        accepted;
    int          cyc;
    int          value_errors;
    int          protocol_errors;
    int          seed;

    warp_issue DUT (.*);

    initial begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the stimulus finished");
        $display(">>> FAIL");
        $finish;
    end

    function automatic logic [68:0] pack_bundle(input logic bit0, input logic [4:0] rs1,
            input logic [4:0] rs2, input logic [4:0] rd, input logic [31:0] imm,
            input logic [3:0] pipe, input logic [1:0] sh, input logic [7:0] actrl,
            input logic [6:0] lctrl);
        pack_bundle = {lctrl, actrl, sh, pipe, imm, rd, rs2, rs1, bit0};
    endfunction

    // registers an instruction reads or writes, rs2 left out when marked unused
    function automatic logic [31:0] mask_of(input int b);
        logic [31:0] m;
        m = (32'd1 << b_rs1[b]) | (32'd1 << b_rd[b]);
        if (!b_sh[b][0]) begin
            m = m | (32'd1 << b_rs2[b]);
        end
        mask_of = m;
    endfunction

    // both bundles free of hazards, on different units and both units ready
    function automatic logic pair_issuable();
        logic rdy0;
        logic rdy1;
        rdy0 = (b_pipe[0] == 4'd0) ? i_xarith_ready : i_xlogic_ready;
        rdy1 = (b_pipe[1] == 4'd0) ? i_xarith_ready : i_xlogic_ready;
        pair_issuable = rdy0 && rdy1 && b_rd[0] != b_rd[1] && b_pipe[0] != b_pipe[1] &&
                        (mask_of(0) & sb_model) == 32'd0 &&
                        (mask_of(1) & sb_model) == 32'd0;
    endfunction

    task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("Fail time=%0t %s got %h expected %h", $time, name, got, exp);
            value_errors++;
        end
    endtask

    task automatic report_failure(input string msg);
        $display("Error time=%0t %s", $time, msg);
        protocol_errors++;
    endtask

    task automatic take_delivery(input int unit, input int bank, input logic unit_rdy,
            inout logic [31:0] new_res);
        if (b_pipe[bank] != 4'(unit)) begin
            report_failure($sformatf("bundle %0d arrived on the wrong unit", bank));
        end
        if (delivered[bank]) begin
            report_failure($sformatf("bundle %0d delivered twice or with no pair", bank));
        end
        if ((mask_of(bank) & sb_model) != 32'd0) begin
            report_failure($sformatf("bundle %0d dispatched over a busy register", bank));
        end
        if (!unit_rdy) begin
            report_failure($sformatf("bundle %0d dispatched while its unit was busy", bank));
        end
        if (bank == 1 && !ir_prev) begin
            report_failure("bundle 1 dispatched without an input ready pulse");
        end
        delivered[bank] = 1'b1;
        dcyc[bank] = cyc;
        if (b_rd[bank] != 5'd0) begin
            new_res = new_res | (32'd1 << b_rd[bank]);
        end
    endtask

    // runs at the falling edge, where all DUT outputs are settled
    task automatic check_cycle();
        logic [31:0] new_res;
        int          b;
        new_res = 32'd0;
        if (cyc == 0 && i_input_valid) begin
            check_val("o_rs1_addr", 64'(o_rs1_addr), 64'(b_rs1[0]));
            check_val("o_rs2_addr", 64'(o_rs2_addr), 64'(b_rs2[0]));
            check_val("o_rs3_addr", 64'(o_rs3_addr), 64'(b_rs1[1]));
            check_val("o_rs4_addr", 64'(o_rs4_addr), 64'(b_rs2[1]));
        end
        if (o_xarith_valid) begin
            b = int'(o_xarith_banksel);
            take_delivery(0, b, ardy_prev, new_res);
            check_val("o_xarith_rd", 64'(o_xarith_rd), 64'(b_rd[b]));
            check_val("o_xarith_op2_sel", 64'(o_xarith_op2_sel), 64'(b_sh[b][1]));
            check_val("o_xarith_imm", o_xarith_imm, {{32{b_imm[b][31]}}, b_imm[b]});
            check_val("xarith controls", 64'({o_xarith_word, o_xarith_branch_invert,
                o_xarith_branch_equal, o_xarith_cmp_mode, o_xarith_unsigned,
                o_xarith_sub, o_xarith_opsel}), 64'(b_actrl[b]));
        end
        if (o_xlogic_valid) begin
            b = int'(o_xlogic_banksel);
            take_delivery(1, b, lrdy_prev, new_res);
            check_val("o_xlogic_rd", 64'(o_xlogic_rd), 64'(b_rd[b]));
            check_val("o_xlogic_op2_sel", 64'(o_xlogic_op2_sel), 64'(b_sh[b][1]));
            check_val("o_xlogic_imm", o_xlogic_imm, {{32{b_imm[b][31]}}, b_imm[b]});
            check_val("xlogic controls", 64'({o_xlogic_word, o_xlogic_sll,
                o_xlogic_invert, o_xlogic_opsel}), 64'(b_lctrl[b]));
        end
        if (o_input_ready) begin
            if (accepted) begin
                report_failure("input ready pulsed twice for one pair");
            end
            accepted = 1'b1;
        end
        // a reserve wins over a retire of the same register
        sb_model  = (sb_model & ~ret_prev) | new_res;
        // an unblocked pair is taken in the very cycle it is offered
        if (i_input_valid && !delivered[0] && !o_input_ready && pair_issuable()) begin
            report_failure("a pair with no hazard and ready units was not accepted");
        end
        ret_prev  = i_inst0_retire | i_inst1_retire;
        ir_prev   = o_input_ready;
        ardy_prev = i_xarith_ready;
        lrdy_prev = i_xlogic_ready;
    endtask

    initial begin
        int          base;
        logic [31:0] rnd;
        logic [31:0] a_low;
        logic [31:0] l_low;
        logic [31:0] r_mask;
        logic [31:0] r_cyc;
        logic [31:0] exp_order;
        i_rst_n = 1'b0;
        i_input_valid = 1'b0;
        i_bundle0 = '0;
        i_bundle1 = '0;
        i_xarith_ready = 1'b1;
        i_xlogic_ready = 1'b1;
        i_inst0_retire = '0;
        i_inst1_retire = '0;
        seed = 32'he779_cb63;
        value_errors = 0;
        protocol_errors = 0;
        sb_model = '0;
        ret_prev = '0;
        ir_prev = 1'b0;
        ardy_prev = 1'b1;
        lrdy_prev = 1'b1;
        $readmemh("testbench/issue_stim.txt", stim_mem);
        repeat (2) @(posedge i_clk);
        #2 i_rst_n = 1'b1;

        for (int step = 0; step < NSTEPS; step++) begin
            base = step * WORDS;
            for (int b = 0; b < 2; b++) begin
                rnd = $random(seed);
                b_rs1[b]   = stim_mem[base + b*8][4:0];
                b_rs2[b]   = stim_mem[base + b*8 + 1][4:0];
                b_rd[b]    = stim_mem[base + b*8 + 2][4:0];
                b_pipe[b]  = stim_mem[base + b*8 + 3][3:0];
                b_sh[b]    = stim_mem[base + b*8 + 4][1:0];
                b_actrl[b] = stim_mem[base + b*8 + 5][7:0];
                b_lctrl[b] = stim_mem[base + b*8 + 6][6:0];
                // the low immediate half and the spare bit 0 come from the generator
                b_imm[b]   = {stim_mem[base + b*8 + 7][15:0], rnd[15:0]};
                delivered[b] = 1'b0;
                dcyc[b] = 0;
            end
            a_low     = stim_mem[base + 16];
            l_low     = stim_mem[base + 17];
            r_mask    = stim_mem[base + 18];
            r_cyc     = stim_mem[base + 19];
            exp_order = stim_mem[base + 20];
            accepted  = 1'b0;
            cyc       = 0;
            while (!(delivered[0] && delivered[1]) && cyc < STEP_CYCLES) begin
                @(posedge i_clk);
                #2;
                i_input_valid  = !accepted;
                i_bundle0      = pack_bundle(rnd[16], b_rs1[0], b_rs2[0], b_rd[0], b_imm[0],
                                             b_pipe[0], b_sh[0], b_actrl[0], b_lctrl[0]);
                i_bundle1      = pack_bundle(rnd[17], b_rs1[1], b_rs2[1], b_rd[1], b_imm[1],
                                             b_pipe[1], b_sh[1], b_actrl[1], b_lctrl[1]);
                i_xarith_ready = cyc >= a_low;
                i_xlogic_ready = cyc >= l_low;
                i_inst0_retire = (cyc == r_cyc && step % 2 == 0) ? r_mask : 32'd0;
                i_inst1_retire = (cyc == r_cyc && step % 2 == 1) ? r_mask : 32'd0;
                @(negedge i_clk);
                check_cycle();
                cyc++;
            end
            if (!(delivered[0] && delivered[1])) begin
                report_failure($sformatf("step %0d: pair was not fully dispatched", step));
            end else if (exp_order == 0 && dcyc[0] != dcyc[1]) begin
                report_failure($sformatf("step %0d: pair should dispatch together", step));
            end else if (exp_order == 1 && dcyc[0] >= dcyc[1]) begin
                report_failure($sformatf("step %0d: bundle 1 should follow bundle 0", step));
            end
            if (!accepted) begin
                report_failure($sformatf("step %0d: pair never accepted", step));
            end
        end

        // a few idle cycles, in which no valid may appear
        delivered[0] = 1'b1;
        delivered[1] = 1'b1;
        accepted = 1'b1;
        repeat (3) begin
            @(posedge i_clk);
            #2;
            i_input_valid  = 1'b0;
            i_inst0_retire = '0;
            i_inst1_retire = '0;
            @(negedge i_clk);
            check_cycle();
        end

        $display("value errors: %0d, protocol errors: %0d", value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: testbench/issue_stim.txt
// per bundle: rs1 rs2 rd pipe shared xarith_ctrl xlogic_ctrl imm_hi, bundle 0 then 1
// then: xarith_low_cycles xlogic_low_cycles retire_mask retire_cycle order(0 together, 1 split)
01 02 03 0 0 a5 3c 8001  04 05 06 1 2 11 55 1234  0 0 00000000 0 0
07 08 09 0 0 5a 01 7fff  0a 0b 0c 0 1 c3 7e ffff  0 0 00000048 0 1
09 01 0d 1 0 0f 2a 0000  01 02 0e 0 3 f0 15 8000  0 0 00000200 3 0
01 02 0f 0 0 33 41 4321  0c 00 10 1 1 cc 62 fedc  0 0 00001000 4 1
01 02 11 0 1 96 07 0100  03 04 11 1 0 69 70 8888  0 0 00020000 5 1
01 02 12 0 0 81 12 2222  05 07 13 1 0 18 24 9999  3 0 0003e000 0 0
01 02 14 1 0 42 33 aaaa  03 04 15 0 3 24 4c 5555  0 4 000c0000 2 0
01 02 16 1 1 7e 6a 0f0f  05 06 17 1 0 e7 19 f0f0  0 2 00300000 1 1
01 02 18 0 0 3c 5f 1357  03 04 19 1 2 c3 2d 9bdf  0 3 00c00000 0 1
01 02 00 0 0 55 0b 7531  03 04 1a 1 0 aa 36 eca8  0 0 03000000 0 0
00 00 00 1 0 12 48 8421  00 00 1b 0 0 21 27 1248  0 0 04000000 0 0
00 00 00 0 0 99 66 c0de  00 00 00 1 0 66 19 beef  0 0 08000000 0 1

// File: vlog.f
rtl/issue_pkg.sv
rtl/bundle_unpack.sv
rtl/reservation_table.sv
rtl/dispatch_ctrl.sv
rtl/xarith_port.sv
rtl/xlogic_port.sv
rtl/warp_issue.sv
testbench/tb_warp_issue.sv

// File: Makefile
# Verilator build for the warp_issue testbench

VERILATOR ?= verilator
TOP       ?= tb_warp_issue
FLIST     ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
PASS_MSG  ?= >>> PASS

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FLIST) $(shell cat $(FLIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: compile
	./$(SIM_BIN) > $(LOG) 2>&1; true
	cat $(LOG)
	@if grep -qx '$(PASS_MSG)' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
